// ==== rtl/nm_host_pkg.sv ====
package nm_host_pkg;

    //////////////////////////////
    // host parameter select
    //////////////////////////////

    // which field a host write lands in
    typedef enum logic [2:0]
    {
        SEL_HALF_CNT    = 3'd0,
        SEL_PPS_COEF    = 3'd1,
        SEL_MN_GAIN     = 3'd2,
        SEL_DECAY_SHIFT = 3'd3
    } param_sel_e;

    //////////////////////////////
    // parameter set
    //////////////////////////////

    typedef struct packed
    {
        // tick half period, in clock cycles minus one
        logic [15:0] half_cnt;
        // spindle drive gain
        logic [15:0] pps_coef;
        // spikes to force gain
        logic [15:0] mn_gain;
        // force leak as a right shift
        logic [3:0]  decay_shift;
    } host_params_t;

    // values loaded on reset_global
    localparam logic [15:0] RST_HALF_CNT    = 16'd3;
    localparam logic [15:0] RST_PPS_COEF    = 16'd8;
    localparam logic [15:0] RST_MN_GAIN     = 16'd1;
    localparam logic [3:0]  RST_DECAY_SHIFT = 4'd2;

endpackage

// ==== rtl/nm_model_pkg.sv ====
package nm_model_pkg;

    //////////////////////////////
    // widths and sizes
    //////////////////////////////

    localparam int POS_W      = 16;
    localparam int WAVE_DEPTH = 64;
    localparam int WAVE_AW    = 6;
    localparam int ACC_W      = 32;
    localparam int FORCE_W    = 32;
    localparam int CNT_W      = 16;

    // motoneuron threshold, one spike per crossing
    localparam logic [ACC_W-1:0] FIRE_THRESH = 32'd4096;

    // rest lengths for the two muscles around the elbow
    localparam logic [POS_W-1:0] BIC_REST = 16'd40000;
    localparam logic [POS_W-1:0] TRI_REST = 16'd8000;

    // waveform buffer states
    typedef enum logic
    {
        WAVE_FILL = 1'b0,
        WAVE_PLAY = 1'b1
    } wave_state_e;

    // what a motor channel shows to the outside
    typedef struct packed
    {
        logic [POS_W-1:0]   len;
        logic [CNT_W-1:0]   spk_cnt;
        logic [FORCE_W-1:0] force_val;
    } chan_obs_t;

endpackage

// ==== rtl/nm_param_bank.sv ====
`timescale 1ns/1ps

module nm_param_bank
(
    input  logic                      ep50trig,
    input  logic                      reset_global,
    input  logic                      i_cfg_valid,
    input  nm_host_pkg::param_sel_e   i_cfg_sel,
    input  logic [15:0]               i_cfg_data,
    output nm_host_pkg::host_params_t o_params
);

    import nm_host_pkg::*;

    host_params_t params_q;

    //////////////////////////////
    // strobed host writes
    //////////////////////////////

    // one field per strobe, visible on the next cycle
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            params_q.half_cnt    <= RST_HALF_CNT;
            params_q.pps_coef    <= RST_PPS_COEF;
            params_q.mn_gain     <= RST_MN_GAIN;
            params_q.decay_shift <= RST_DECAY_SHIFT;
        end
        else if (i_cfg_valid)
        begin
            case (i_cfg_sel)
                SEL_HALF_CNT:
                begin
                    params_q.half_cnt <= i_cfg_data;
                end
                SEL_PPS_COEF:
                begin
                    params_q.pps_coef <= i_cfg_data;
                end
                SEL_MN_GAIN:
                begin
                    params_q.mn_gain <= i_cfg_data;
                end
                SEL_DECAY_SHIFT:
                begin
                    // only the low nibble is meaningful
                    params_q.decay_shift <= i_cfg_data[3:0];
                end
                default:
                begin
                    // unknown opcode, keep everything
                    params_q <= params_q;
                end
            endcase
        end
    end

    assign o_params = params_q;

endmodule

// ==== rtl/nm_tick_gen.sv ====
`timescale 1ns/1ps

module nm_tick_gen
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        i_sim_restart,
    input  logic [15:0] i_half_cnt,
    output logic        o_sim_tick
);

    logic [16:0] cnt_q;
    logic [16:0] cnt_last;

    // last count of a window is 2*half_cnt + 1
    assign cnt_last = {i_half_cnt, 1'b1};

    // greater-or-equal covers a shrinking half_cnt mid-window
    assign o_sim_tick = (cnt_q >= cnt_last);

    //////////////////////////////
    // window counter
    //////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_restart)
        begin
            cnt_q <= '0;
        end
        else if (o_sim_tick)
        begin
            cnt_q <= '0;
        end
        else
        begin
            cnt_q <= cnt_q + 17'd1;
        end
    end

endmodule

// ==== rtl/nm_waveform_buffer.sv ====
`timescale 1ns/1ps

module nm_waveform_buffer
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        i_sim_restart,
    input  logic        i_pipe_valid,
    input  logic [15:0] i_pipe_data,
    input  logic        i_sim_tick,
    output logic [15:0] o_pos,
    output logic        o_wave_playing
);

    import nm_model_pkg::*;

    wave_state_e         state_q;
    logic [POS_W-1:0]    mem [WAVE_DEPTH];
    logic [WAVE_AW:0]    count_q;
    logic [WAVE_AW-1:0]  wr_idx;
    logic [WAVE_AW-1:0]  rd_idx_q;
    logic [WAVE_AW:0]    rd_inc;
    logic [WAVE_AW-1:0]  rd_next;
    logic                wr_en;
    logic [POS_W-1:0]    pos_q;

    // samples land in order, so the count doubles as write index
    assign wr_idx = count_q[WAVE_AW-1:0];
    assign wr_en  = !i_sim_restart && (state_q == WAVE_FILL) && i_pipe_valid
                    && (count_q < WAVE_DEPTH);

    // cyclic read pointer over the stored samples
    assign rd_inc  = {1'b0, rd_idx_q} + 1'b1;
    assign rd_next = (rd_inc >= count_q) ? '0 : rd_inc[WAVE_AW-1:0];

    //////////////////////////////
    // sample memory
    //////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (wr_en)
        begin
            mem[wr_idx] <= i_pipe_data;
        end
    end

    //////////////////////////////
    // fill / play control
    //////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            state_q  <= WAVE_FILL;
            count_q  <= '0;
            rd_idx_q <= '0;
            pos_q    <= '0;
        end
        else if (i_sim_restart)
        begin
            // pos keeps the last sample on restart
            state_q  <= WAVE_FILL;
            count_q  <= '0;
            rd_idx_q <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                count_q <= count_q + 1'b1;
            end
            if (i_sim_tick && (state_q == WAVE_FILL) && (count_q != '0))
            begin
                state_q  <= WAVE_PLAY;
                rd_idx_q <= '0;
                pos_q    <= mem[0];
            end
            else if (i_sim_tick && (state_q == WAVE_PLAY))
            begin
                rd_idx_q <= rd_next;
                pos_q    <= mem[rd_next];
            end
        end
    end

    assign o_pos          = pos_q;
    assign o_wave_playing = (state_q == WAVE_PLAY);

endmodule

// ==== rtl/nm_motor_channel.sv ====
`timescale 1ns/1ps

module nm_motor_channel
#(
    parameter bit FLEXOR = 1'b1
)
(
    input  logic                      ep50trig,
    input  logic                      reset_global,
    input  logic                      i_sim_restart,
    input  logic                      i_sim_tick,
    input  logic                      i_wave_playing,
    input  logic [15:0]               i_pos,
    input  nm_host_pkg::host_params_t i_params,
    output nm_model_pkg::chan_obs_t   o_obs,
    output logic                      o_spike
);

    import nm_host_pkg::*;
    import nm_model_pkg::*;

    chan_obs_t           obs_q;
    logic [POS_W-1:0]    len_next;
    logic [ACC_W-1:0]    acc_q;
    logic [ACC_W-1:0]    acc_base;
    logic [ACC_W-1:0]    acc_next;
    logic [ACC_W-1:0]    drive;
    logic                fire;
    logic [CNT_W-1:0]    win_cnt_q;
    logic [CNT_W-1:0]    win_total;
    logic [FORCE_W-1:0]  force_leak;
    logic [FORCE_W-1:0]  force_gain;
    logic [FORCE_W:0]    force_sum;
    logic [FORCE_W-1:0]  force_next;

    function automatic logic [ACC_W-1:0] sat_add(input logic [ACC_W-1:0] a,
                                                 input logic [ACC_W-1:0] b);
        logic [ACC_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[ACC_W] ? '1 : s[ACC_W-1:0];
    endfunction

    //////////////////////////////
    // muscle length and spindle
    //////////////////////////////

    // biceps shortens as the elbow flexes, triceps lengthens
    always_comb
    begin
        if (FLEXOR)
        begin
            len_next = (i_pos > BIC_REST) ? '0 : BIC_REST - i_pos;
        end
        else
        begin
            len_next = (i_pos < TRI_REST) ? '0 : i_pos - TRI_REST;
        end
    end

    // rate proportional to length, coarse by 16
    assign drive = ACC_W'(obs_q.len >> 4) * ACC_W'(i_params.pps_coef);

    //////////////////////////////
    // motoneuron
    //////////////////////////////

    assign fire     = (acc_q >= FIRE_THRESH);
    assign acc_base = fire ? acc_q - FIRE_THRESH : acc_q;
    assign acc_next = i_wave_playing ? sat_add(acc_base, drive) : acc_base;

    // window count including a spike in this cycle
    assign win_total = (fire && (win_cnt_q != '1)) ? win_cnt_q + 1'b1 : win_cnt_q;

    // leaky force, refreshed once per tick
    assign force_leak = obs_q.force_val - (obs_q.force_val >> i_params.decay_shift);
    assign force_gain = FORCE_W'(win_total) * FORCE_W'(i_params.mn_gain);
    assign force_sum  = {1'b0, force_leak} + {1'b0, force_gain};
    assign force_next = force_sum[FORCE_W] ? '1 : force_sum[FORCE_W-1:0];

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_restart)
        begin
            obs_q     <= '0;
            acc_q     <= '0;
            win_cnt_q <= '0;
        end
        else
        begin
            obs_q.len <= len_next;
            acc_q     <= acc_next;
            if (i_sim_tick)
            begin
                obs_q.spk_cnt   <= win_total;
                obs_q.force_val <= force_next;
                win_cnt_q       <= '0;
            end
            else
            begin
                win_cnt_q <= win_total;
            end
        end
    end

    assign o_obs   = obs_q;
    assign o_spike = fire;

endmodule

// ==== rtl/nm_loop_top.sv ====
`timescale 1ns/1ps

module nm_loop_top
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_cfg_valid,
    input  nm_host_pkg::param_sel_e i_cfg_sel,
    input  logic [15:0]             i_cfg_data,
    input  logic                    i_pipe_valid,
    input  logic [15:0]             i_pipe_data,
    input  logic                    i_sim_restart,
    output logic                    o_sim_tick,
    output logic [15:0]             o_pos,
    output logic                    o_wave_playing,
    output nm_model_pkg::chan_obs_t o_bic,
    output nm_model_pkg::chan_obs_t o_tri,
    output logic                    o_bic_spike,
    output logic                    o_tri_spike
);

    import nm_host_pkg::*;

    host_params_t params;

    //////////////////////////////
    // host side
    //////////////////////////////

    nm_param_bank u_params
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_cfg_valid  (i_cfg_valid),
        .i_cfg_sel    (i_cfg_sel),
        .i_cfg_data   (i_cfg_data),
        .o_params     (params)
    );

    nm_tick_gen u_tick
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_sim_restart (i_sim_restart),
        .i_half_cnt    (params.half_cnt),
        .o_sim_tick    (o_sim_tick)
    );

    // joint position source
    nm_waveform_buffer u_wave
    (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_sim_restart  (i_sim_restart),
        .i_pipe_valid   (i_pipe_valid),
        .i_pipe_data    (i_pipe_data),
        .i_sim_tick     (o_sim_tick),
        .o_pos          (o_pos),
        .o_wave_playing (o_wave_playing)
    );

    //////////////////////////////
    // biceps and triceps
    //////////////////////////////

    nm_motor_channel #(.FLEXOR(1'b1)) u_bic
    (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_sim_restart  (i_sim_restart),
        .i_sim_tick     (o_sim_tick),
        .i_wave_playing (o_wave_playing),
        .i_pos          (o_pos),
        .i_params       (params),
        .o_obs          (o_bic),
        .o_spike        (o_bic_spike)
    );

    nm_motor_channel #(.FLEXOR(1'b0)) u_tri
    (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_sim_restart  (i_sim_restart),
        .i_sim_tick     (o_sim_tick),
        .i_wave_playing (o_wave_playing),
        .i_pos          (o_pos),
        .i_params       (params),
        .o_obs          (o_tri),
        .o_spike        (o_tri_spike)
    );

endmodule

// ==== dv/nm_loop_assertions.sv ====
`timescale 1ns/1ps

module nm_loop_assertions
(
    input logic        ep50trig,
    input logic        reset_global,
    input logic        i_sim_restart,
    input logic        o_sim_tick,
    input logic [15:0] o_pos,
    input logic        o_wave_playing
);

    // number of failed properties so far
    int fail_count = 0;

    //////////////////////////////
    // tick, restart and pos
    //////////////////////////////

    tick_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_sim_tick |=> !o_sim_tick)
    else
    begin
        $error("o_sim_tick high in two consecutive cycles");
        fail_count++;
    end

    restart_stops_play: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_sim_restart |=> !o_wave_playing)
    else
    begin
        $error("o_wave_playing high right after a restart");
        fail_count++;
    end

    // pos only moves when a tick advanced the buffer
    pos_on_tick: assert property (@(posedge ep50trig) disable iff (reset_global)
        $changed(o_pos) |-> $past(o_sim_tick))
    else
    begin
        $error("o_pos changed without a tick in the previous cycle");
        fail_count++;
    end

endmodule

bind nm_loop_top nm_loop_assertions u_assert
(
    .ep50trig       (ep50trig),
    .reset_global   (reset_global),
    .i_sim_restart  (i_sim_restart),
    .o_sim_tick     (o_sim_tick),
    .o_pos          (o_pos),
    .o_wave_playing (o_wave_playing)
);

// ==== dv/tb_nm_loop.sv ====
`timescale 1ns/1ps

module tb_nm_loop;

    import nm_host_pkg::*;
    import nm_model_pkg::*;

    localparam int CLK_NS = 20;
    // cycle budgets of the six phases, in order
    localparam int BUDGET = 40 + 500 + 1300 + 1100 + 500 + 4000;
    localparam int MARGIN = 500;
    localparam longint SAT32 = 64'hFFFF_FFFF;

    logic         ep50trig;
    logic         reset_global;
    logic         i_cfg_valid;
    param_sel_e   i_cfg_sel;
    logic [15:0]  i_cfg_data;
    logic         i_pipe_valid;
    logic [15:0]  i_pipe_data;
    logic         i_sim_restart;
    logic         o_sim_tick;
    logic [15:0]  o_pos;
    logic         o_wave_playing;
    chan_obs_t    o_bic;
    chan_obs_t    o_tri;
    logic         o_bic_spike;
    logic         o_tri_spike;

    // reference model state, index 0 is biceps
    host_params_t m_par;
    logic [16:0]  m_cnt;
    logic         m_play;
    logic [15:0]  m_mem [WAVE_DEPTH];
    int           m_count;
    int           m_rd;
    logic [15:0]  m_pos;
    chan_obs_t    m_obs [2];
    longint       m_acc [2];
    longint       m_win [2];
    logic [31:0]  rng;

    nm_loop_top u_dut (.*);

    initial
    begin
        ep50trig = 1'b0;
        forever #(CLK_NS / 2) ep50trig = ~ep50trig;
    end

    //////////////////////////////
    // random numbers and errors
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift32(rng);
        return int'(rng % n);
    endfunction

    // anywhere, or within 2000 of one of the rest lengths
    function automatic logic [15:0] pick_position(input bit near_rest);
        logic [15:0] base;
        if (!near_rest)
            return 16'(rand_below(65536));
        base = rand_below(2) ? BIC_REST : TRI_REST;
        return base + 16'(rand_below(4000)) - 16'd2000;
    endfunction

    task automatic value_error(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        $display("Error: %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        $display("tests failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    task automatic model_reset();
        m_par.half_cnt    = RST_HALF_CNT;
        m_par.pps_coef    = RST_PPS_COEF;
        m_par.mn_gain     = RST_MN_GAIN;
        m_par.decay_shift = RST_DECAY_SHIFT;
        m_cnt   = '0;
        m_play  = 1'b0;
        m_count = 0;
        m_rd    = 0;
        m_pos   = '0;
        for (int c = 0; c < 2; c++)
        begin
            m_obs[c] = '0;
            m_acc[c] = 0;
            m_win[c] = 0;
        end
    endtask

    // one rising edge with the inputs now applied
    task automatic model_step();
        logic   tick;
        logic   fire;
        logic   wr;
        longint len;
        longint acc;
        longint win;
        longint frc;
        tick = (int'(m_cnt) >= 2 * int'(m_par.half_cnt) + 1);
        wr   = !m_play && i_pipe_valid && (m_count < WAVE_DEPTH);
        // channels see the old pos, play flag and parameters
        for (int c = 0; c < 2; c++)
        begin
            len = (c == 0) ? longint'(BIC_REST) - longint'(m_pos)
                           : longint'(m_pos) - longint'(TRI_REST);
            len  = (len < 0) ? 0 : len;
            fire = (m_acc[c] >= FIRE_THRESH);
            acc  = fire ? m_acc[c] - FIRE_THRESH : m_acc[c];
            if (m_play)
                acc = acc + longint'(m_obs[c].len >> 4) * longint'(m_par.pps_coef);
            acc = (acc > SAT32) ? SAT32 : acc;
            win = (fire && m_win[c] < 65535) ? m_win[c] + 1 : m_win[c];
            frc = longint'(m_obs[c].force_val)
                  - longint'(m_obs[c].force_val >> m_par.decay_shift)
                  + win * longint'(m_par.mn_gain);
            if (i_sim_restart)
            begin
                m_obs[c] = '0;
                m_acc[c] = 0;
                m_win[c] = 0;
            end
            else
            begin
                m_obs[c].len = 16'(len);
                m_acc[c] = acc;
                m_win[c] = tick ? 0 : win;
                if (tick)
                begin
                    m_obs[c].spk_cnt   = 16'(win);
                    m_obs[c].force_val = 32'((frc > SAT32) ? SAT32 : frc);
                end
            end
        end
        if (i_sim_restart)
        begin
            m_play  = 1'b0;
            m_count = 0;
            m_rd    = 0;
        end
        else
        begin
            if (tick && !m_play && m_count != 0)
            begin
                m_play = 1'b1;
                m_rd   = 0;
                m_pos  = m_mem[0];
            end
            else if (tick && m_play)
            begin
                m_rd  = (m_rd + 1 >= m_count) ? 0 : m_rd + 1;
                m_pos = m_mem[m_rd];
            end
            if (wr)
            begin
                m_mem[m_count] = i_pipe_data;
                m_count++;
            end
        end
        m_cnt = (i_sim_restart || tick) ? 17'd0 : m_cnt + 17'd1;
        if (i_cfg_valid)
        begin
            case (i_cfg_sel)
                SEL_HALF_CNT:    m_par.half_cnt = i_cfg_data;
                SEL_PPS_COEF:    m_par.pps_coef = i_cfg_data;
                SEL_MN_GAIN:     m_par.mn_gain = i_cfg_data;
                SEL_DECAY_SHIFT: m_par.decay_shift = i_cfg_data[3:0];
                default:         ;
            endcase
        end
    endtask

    task automatic check_outputs();
        logic exp_tick;
        exp_tick = (int'(m_cnt) >= 2 * int'(m_par.half_cnt) + 1);
        assert (u_dut.u_assert.fail_count == 0)
        else abort_run("a concurrent assertion bound into nm_loop_top failed");
        assert (o_sim_tick == exp_tick) else value_error("o_sim_tick", o_sim_tick, exp_tick);
        assert (o_pos == m_pos) else value_error("o_pos", o_pos, m_pos);
        assert (o_wave_playing == m_play)
        else value_error("o_wave_playing", o_wave_playing, m_play);
        assert (o_bic == m_obs[0]) else value_error("o_bic", o_bic, m_obs[0]);
        assert (o_tri == m_obs[1]) else value_error("o_tri", o_tri, m_obs[1]);
        assert (o_bic_spike == (m_acc[0] >= FIRE_THRESH))
        else value_error("o_bic_spike", o_bic_spike, m_acc[0] >= FIRE_THRESH);
        assert (o_tri_spike == (m_acc[1] >= FIRE_THRESH))
        else value_error("o_tri_spike", o_tri_spike, m_acc[1] >= FIRE_THRESH);
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // inputs set at a falling edge are taken at the next rising edge
    task automatic step();
        model_step();
        @(posedge ep50trig);
        @(negedge ep50trig);
        check_outputs();
        i_cfg_valid   = 1'b0;
        i_pipe_valid  = 1'b0;
        i_sim_restart = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic host_write(input param_sel_e sel, input logic [15:0] data);
        i_cfg_valid = 1'b1;
        i_cfg_sel   = sel;
        i_cfg_data  = data;
        step();
    endtask

    task automatic pipe_write(input logic [15:0] data);
        i_pipe_valid = 1'b1;
        i_pipe_data  = data;
        step();
    endtask

    task automatic restart_sim();
        i_sim_restart = 1'b1;
        step();
    endtask

    task automatic random_param_write();
        int sel;
        sel = rand_below(8);
        // short tick periods keep the run moving
        if (sel == 0)
            host_write(SEL_HALF_CNT, 16'(rand_below(6)));
        else
            host_write(param_sel_e'(sel), 16'(rand_below(65536)));
    endtask

    task automatic wait_playing(input int limit);
        int waited;
        waited = 0;
        while (!o_wave_playing)
        begin
            if (waited == limit)
                abort_run("waveform buffer never entered playback");
            step();
            waited++;
        end
    endtask

    // long window while filling so no tick cuts the fill short
    task automatic load_wave(input int n, input bit near_rest, input logic [15:0] half);
        host_write(SEL_HALF_CNT, 16'd40);
        restart_sim();
        repeat (n) pipe_write(pick_position(near_rest));
        wait_playing(100);
        host_write(SEL_HALF_CNT, half);
    endtask

    initial
    begin
        #(longint'(BUDGET + MARGIN) * CLK_NS);
        abort_run("simulation timed out, the test phases ran past their cycle budget");
    end

    initial
    begin
        int pick;
        rng           = 32'd19;
        reset_global  = 1'b1;
        i_cfg_valid   = 1'b0;
        i_cfg_sel     = SEL_HALF_CNT;
        i_cfg_data    = '0;
        i_pipe_valid  = 1'b0;
        i_pipe_data   = '0;
        i_sim_restart = 1'b0;
        model_reset();
        repeat (5) @(posedge ep50trig);
        @(negedge ep50trig);
        reset_global = 1'b0;
        // quiet after reset, ticks at the reset period
        check_outputs();
        idle(40);
        // parameter writes while a short waveform plays
        load_wave(5, 1'b0, 16'd3);
        repeat (20)
        begin
            random_param_write();
            idle(15);
        end
        // fill and playback, first pass overfills, writes during play dropped
        for (int i = 0; i < 4; i++)
        begin
            load_wave((i == 0) ? 70 : rand_below(20) + 1, 1'b0, 16'd2);
            repeat (30)
            begin
                pipe_write(pick_position(1'b0));
                idle(4);
            end
        end
        // lengths around both rest offsets
        for (int i = 0; i < 2; i++)
        begin
            host_write(SEL_PPS_COEF, 16'(rand_below(400) + 1));
            load_wave(16, 1'b1, 16'd3);
            idle(400);
        end
        // restart mid-play, then a new waveform from sample 0
        load_wave(12, 1'b1, 16'd2);
        idle(60);
        restart_sim();
        idle(30);
        load_wave(9, 1'b0, 16'd1);
        idle(60);
        // everything mixed
        repeat (4000)
        begin
            pick = rand_below(200);
            if (pick < 6)
                random_param_write();
            else if (pick < 30)
                pipe_write(pick_position(pick[0]));
            else if (pick == 30)
                restart_sim();
            else
                step();
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/nm_host_pkg.sv
rtl/nm_model_pkg.sv
rtl/nm_param_bank.sv
rtl/nm_tick_gen.sv
rtl/nm_waveform_buffer.sv
rtl/nm_motor_channel.sv
rtl/nm_loop_top.sv
dv/nm_loop_assertions.sv
dv/tb_nm_loop.sv

// ==== Makefile ====
# Verilator flow for the elbow loop testbench

VERILATOR ?= verilator
TOP       ?= tb_nm_loop
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
